//--- design/exe_alu.sv
`timescale 1ns/1ns

module exe_alu (
	input  logic [exe_pkg::XLEN-1:0] operand_a_i,
	input  logic [exe_pkg::XLEN-1:0] operand_b_i,
	input  exe_pkg::alu_op_t         alu_op_i,
	output logic [exe_pkg::XLEN-1:0] result_o,
	output exe_pkg::exe_alu_stat_t   stat_o
);
	import exe_pkg::*;

	logic [XLEN:0]   diff;     // Extra bit keeps the borrow
	logic [XLEN-1:0] sum;
	logic            ovf;
	logic            sign_a;
	logic            sign_b;

	assign diff   = {1'b0, operand_a_i} - {1'b0, operand_b_i};
	assign sum    = operand_a_i + operand_b_i;
	assign sign_a = operand_a_i[XLEN-1];
	assign sign_b = operand_b_i[XLEN-1];

	// Operands of different sign and result sign flipped from a
	assign ovf = (sign_a ^ sign_b) & (sign_a ^ diff[XLEN-1]);

	// Single comparator shared by slt, sltu and every branch
	always_comb begin
		stat_o.zero     = (diff[XLEN-1:0] == '0);
		stat_o.negative = diff[XLEN-1] ^ ovf;  // Sign corrected for overflow
		stat_o.carry    = diff[XLEN];          // Borrow means a < b unsigned
		stat_o.overflow = ovf;
	end

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    result_o = sum;
			ALU_SUB:    result_o = diff[XLEN-1:0];
			ALU_AND:    result_o = operand_a_i & operand_b_i;
			ALU_OR:     result_o = operand_a_i | operand_b_i;
			ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
			ALU_PASS_A: result_o = operand_a_i;     // Shift by 0 or 1
			default:    result_o = sum;
		endcase
	end

endmodule

//--- design/exe_branch_unit.sv
`timescale 1ns/1ns

module exe_branch_unit (
	input  exe_pkg::exe_op_t         op_i,
	input  logic [exe_pkg::XLEN-1:0] pc_i,
	input  logic [exe_pkg::XLEN-1:0] imm_i,
	input  logic [exe_pkg::XLEN-1:0] operand_a_i,
	input  exe_pkg::exe_alu_stat_t   stat_i,
	output logic [exe_pkg::XLEN-1:0] target_o,
	output logic                     taken_o
);
	import exe_pkg::*;

	logic [XLEN-1:0] pc_rel;    // Branches and jal
	logic [XLEN-1:0] reg_rel;   // jalr base plus offset

	assign pc_rel  = pc_i + imm_i;
	assign reg_rel = operand_a_i + imm_i;

	// jalr drops bit 0 of the computed address
	assign target_o = (op_i == OP_JALR) ? {reg_rel[XLEN-1:1], 1'b0} : pc_rel;

	// Conditions read the a - b status from the ALU
	always_comb begin
		case (op_i)
			OP_BEQ:  taken_o = stat_i.zero;
			OP_BNE:  taken_o = !stat_i.zero;
			OP_BLT:  taken_o = stat_i.negative;
			OP_BGE:  taken_o = !stat_i.negative;
			OP_BLTU: taken_o = stat_i.carry;
			OP_BGEU: taken_o = !stat_i.carry;
			OP_JAL,
			OP_JALR: taken_o = 1'b1;   // Jumps always redirect
			default: taken_o = 1'b0;
		endcase
	end

endmodule

//--- design/exe_control.sv
`timescale 1ns/1ns

module exe_control (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	input  logic                     in_valid_i,
	output logic                     in_ready_o,
	input  exe_pkg::exe_op_t         op_i,
	input  logic [exe_pkg::XLEN-1:0] operand_a_i,
	input  logic [exe_pkg::XLEN-1:0] operand_b_i,
	input  logic                     out_valid_i,   // Output register occupied
	input  logic                     out_ready_i,
	output exe_pkg::alu_op_t         alu_op_o,
	output exe_pkg::wb_sel_t         wb_sel_o,
	output logic                     rd_we_o,
	output logic                     pc_sel_o,      // 1 selects branch target path
	output logic                     load_o,
	exe_shift_if.ctrl                shift
);
	import exe_pkg::*;

	typedef enum logic {ST_IDLE, ST_SHIFT} state_t;

	state_t      state_q;
	alu_op_t     dec_alu;
	wb_sel_t     dec_wb;
	shift_mode_t dec_mode;
	logic        dec_we;
	logic        dec_pc_sel;
	logic        amt_zero;
	logic        amt_one;
	logic        long_shift;  // Needs the sequential shifter
	logic        accept;

	assign amt_zero   = (operand_b_i[SHAMT_W-1:0] == '0);
	assign amt_one    = (operand_b_i[SHAMT_W-1:0] == SHAMT_W'(1));
	assign long_shift = (dec_mode != SHIFT_NONE) && !amt_zero && !amt_one;

	always_comb begin
		dec_alu    = ALU_SUB;  // Comparator by default
		dec_wb     = WB_ALU;
		dec_mode   = SHIFT_NONE;
		dec_we     = 1'b1;
		dec_pc_sel = 1'b0;
		case (op_i)
			OP_ADD:  dec_alu = ALU_ADD;
			OP_AND:  dec_alu = ALU_AND;
			OP_OR:   dec_alu = ALU_OR;
			OP_XOR:  dec_alu = ALU_XOR;
			OP_SLT:  dec_wb  = WB_SLT;
			OP_SLTU: dec_wb  = WB_SLTU;
			OP_SLL:  dec_mode = SHIFT_LEFT;
			OP_SRL:  dec_mode = SHIFT_RIGHT;
			OP_SRA:  dec_mode = SHIFT_ARIGHT;
			OP_LUI:   dec_wb = WB_IMM;
			OP_AUIPC: dec_wb = WB_PC_IMM;
			OP_JAL, OP_JALR: begin
				dec_wb     = WB_LINK;  // Link address pc + 4
				dec_pc_sel = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
				dec_we     = 1'b0;     // Branches write nothing
				dec_pc_sel = 1'b1;
			end
			default: dec_alu = ALU_SUB;
		endcase
		if (dec_mode != SHIFT_NONE) begin
			dec_alu = ALU_PASS_A;
			dec_wb  = amt_zero ? WB_ALU : (amt_one ? WB_ALU_SH1 : WB_SHIFTER);
		end
	end

	// While shifting the inputs belong to the next instruction, so hold shift controls
	assign alu_op_o = (state_q == ST_SHIFT) ? ALU_PASS_A : dec_alu;
	assign wb_sel_o = (state_q == ST_SHIFT) ? WB_SHIFTER : dec_wb;
	assign rd_we_o  = (state_q == ST_SHIFT) ? 1'b1 : dec_we;
	assign pc_sel_o = (state_q == ST_SHIFT) ? 1'b0 : dec_pc_sel;

	assign in_ready_o = (state_q == ST_IDLE) && (!out_valid_i || out_ready_i);
	assign accept     = in_valid_i && in_ready_o;

	assign shift.start   = accept && long_shift;
	assign shift.mode    = dec_mode;
	assign shift.amount  = operand_b_i[SHAMT_W-1:0];
	assign shift.operand = operand_a_i;

	// Single-pass loads on accept, long shift loads once busy falls
	assign load_o = (state_q == ST_IDLE) ? (accept && !long_shift) : !shift.busy;

	always_ff @(posedge clk_i) begin
		if (!rstn_i)
			state_q <= ST_IDLE;
		else if (state_q == ST_IDLE && shift.start)
			state_q <= ST_SHIFT;
		else if (state_q == ST_SHIFT && !shift.busy)
			state_q <= ST_IDLE;  // Result loaded this edge
	end

	a_load_has_room: assert property (@(posedge clk_i) disable iff (!rstn_i)
		load_o |-> (!out_valid_i || out_ready_i));

endmodule

//--- design/exe_pkg.sv
package exe_pkg;

	localparam int XLEN       = 32;  // Data and address width
	localparam int REG_ADDR_W = 5;   // Register file index
	localparam int SHAMT_W    = 5;   // Shift amount field
	localparam int PC_STEP    = 4;   // Bytes per instruction

	typedef enum logic [4:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLT, OP_SLTU,
		OP_SLL, OP_SRL, OP_SRA,
		OP_LUI, OP_AUIPC,
		OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
	} exe_op_t;

	// Pass-through returns operand a, used by shifts of 0 and 1
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_A
	} alu_op_t;

	typedef enum logic [1:0] {
		SHIFT_NONE, SHIFT_LEFT, SHIFT_RIGHT, SHIFT_ARIGHT
	} shift_mode_t;

	// All flags come from a - b
	typedef struct packed {
		logic zero;      // a == b
		logic negative;  // Signed a < b
		logic carry;     // Unsigned a < b, borrow out
		logic overflow;  // Signed overflow of the subtraction
	} exe_alu_stat_t;

	typedef enum logic [2:0] {
		WB_ALU,      // Plain ALU output
		WB_ALU_SH1,  // ALU output moved by one bit
		WB_SHIFTER,  // Sequential shifter
		WB_SLT,      // Signed less-than flag
		WB_SLTU,     // Unsigned less-than flag
		WB_PC_IMM,   // AUIPC
		WB_LINK,     // Return address of jumps
		WB_IMM       // LUI, immediate already placed in the upper bits
	} wb_sel_t;

endpackage

//--- design/exe_shift_if.sv
`timescale 1ns/1ns

interface exe_shift_if;
	import exe_pkg::*;

	logic               start;    // One-cycle kick, only while idle
	shift_mode_t        mode;
	logic [SHAMT_W-1:0] amount;
	logic [XLEN-1:0]    operand;
	logic               busy;     // High until result is final
	logic [XLEN-1:0]    result;   // Held until the next start

	modport ctrl    (output start, output mode, output amount, output operand, input busy);
	modport shifter (input start, input mode, input amount, input operand,
	                 output busy, output result);
	// Writeback also watches start to capture the fields of a long shift
	modport sink    (input start, input result);

endinterface

//--- design/exe_shifter.sv
`timescale 1ns/1ns

module exe_shifter (
	input  logic         clk_i,
	input  logic         rstn_i,
	exe_shift_if.shifter shift
);
	import exe_pkg::*;

	logic [XLEN-1:0]    data_q;     // Working value, becomes the result
	logic [XLEN-1:0]    data_next;
	logic [SHAMT_W-1:0] count_q;    // Steps still to go
	shift_mode_t        mode_q;
	logic               busy_q;

	// One bit per step
	always_comb begin
		case (mode_q)
			SHIFT_LEFT:   data_next = {data_q[XLEN-2:0], 1'b0};
			SHIFT_RIGHT:  data_next = {1'b0, data_q[XLEN-1:1]};
			SHIFT_ARIGHT: data_next = {data_q[XLEN-1], data_q[XLEN-1:1]};  // Sign refill
			default:      data_next = data_q;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			busy_q  <= 1'b0;
			count_q <= '0;
			mode_q  <= SHIFT_NONE;
		end else if (shift.start) begin
			busy_q  <= 1'b1;
			count_q <= shift.amount;
			mode_q  <= shift.mode;
		end else if (busy_q) begin
			count_q <= count_q - 1'b1;
			if (count_q == SHAMT_W'(1))
				busy_q <= 1'b0;  // Last step lands this edge
		end
	end

	always_ff @(posedge clk_i) begin
		if (shift.start)
			data_q <= shift.operand;
		else if (busy_q)
			data_q <= data_next;
	end

	assign shift.busy   = busy_q;
	assign shift.result = data_q;  // Stable once busy drops

	// A second start would corrupt the running shift
	a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		shift.start |-> !busy_q);

endmodule

//--- design/exe_stage.sv
`timescale 1ns/1ns

module exe_stage (
	input  logic                           clk_i,
	input  logic                           rstn_i,
	input  logic                           in_valid_i,
	output logic                           in_ready_o,
	input  exe_pkg::exe_op_t               op_i,
	input  logic [exe_pkg::XLEN-1:0]       operand_a_i,
	input  logic [exe_pkg::XLEN-1:0]       operand_b_i,
	input  logic [exe_pkg::XLEN-1:0]       imm_i,        // Sign-extended, LUI already shifted
	input  logic [exe_pkg::XLEN-1:0]       pc_i,
	input  logic [exe_pkg::REG_ADDR_W-1:0] rd_addr_i,
	output logic                           out_valid_o,
	input  logic                           out_ready_i,
	output logic [exe_pkg::XLEN-1:0]       result_o,
	output logic [exe_pkg::REG_ADDR_W-1:0] rd_addr_o,
	output logic                           rd_we_o,      // Low for branches
	output logic [exe_pkg::XLEN-1:0]       next_pc_o,
	output logic                           branch_taken_o
);
	import exe_pkg::*;

	alu_op_t         alu_op;
	logic [XLEN-1:0] alu_result;
	exe_alu_stat_t   alu_stat;
	wb_sel_t         wb_sel;
	logic            dec_rd_we;
	logic            pc_sel;
	logic            load;
	logic [XLEN-1:0] bj_target;
	logic            bj_taken;

	exe_shift_if shift_bus ();

	exe_control u_control (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.op_i        (op_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.out_valid_i (out_valid_o),   // Occupancy feedback
		.out_ready_i (out_ready_i),
		.alu_op_o    (alu_op),
		.wb_sel_o    (wb_sel),
		.rd_we_o     (dec_rd_we),
		.pc_sel_o    (pc_sel),
		.load_o      (load),
		.shift       (shift_bus.ctrl)
	);

	exe_alu u_alu (
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.alu_op_i    (alu_op),
		.result_o    (alu_result),
		.stat_o      (alu_stat)
	);

	exe_shifter u_shifter (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.shift  (shift_bus.shifter)
	);

	exe_branch_unit u_branch (
		.op_i        (op_i),
		.pc_i        (pc_i),
		.imm_i       (imm_i),
		.operand_a_i (operand_a_i),
		.stat_i      (alu_stat),
		.target_o    (bj_target),
		.taken_o     (bj_taken)
	);

	exe_writeback u_writeback (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.load_i         (load),
		.wb_sel_i       (wb_sel),
		.pc_sel_i       (pc_sel),
		.rd_we_i        (dec_rd_we),
		.alu_result_i   (alu_result),
		.stat_i         (alu_stat),
		.shift_mode_i   (shift_bus.mode),  // Direction for the one-bit case
		.shift          (shift_bus.sink),
		.pc_i           (pc_i),
		.imm_i          (imm_i),
		.target_i       (bj_target),
		.taken_i        (bj_taken),
		.rd_addr_i      (rd_addr_i),
		.out_ready_i    (out_ready_i),
		.out_valid_o    (out_valid_o),
		.result_o       (result_o),
		.rd_addr_o      (rd_addr_o),
		.rd_we_o        (rd_we_o),
		.next_pc_o      (next_pc_o),
		.branch_taken_o (branch_taken_o)
	);

endmodule

//--- design/exe_writeback.sv
`timescale 1ns/1ns

module exe_writeback (
	input  logic                           clk_i,
	input  logic                           rstn_i,
	input  logic                           load_i,
	input  exe_pkg::wb_sel_t               wb_sel_i,
	input  logic                           pc_sel_i,
	input  logic                           rd_we_i,
	input  logic [exe_pkg::XLEN-1:0]       alu_result_i,
	input  exe_pkg::exe_alu_stat_t         stat_i,
	input  exe_pkg::shift_mode_t           shift_mode_i,
	exe_shift_if.sink                      shift,
	input  logic [exe_pkg::XLEN-1:0]       pc_i,
	input  logic [exe_pkg::XLEN-1:0]       imm_i,
	input  logic [exe_pkg::XLEN-1:0]       target_i,
	input  logic                           taken_i,
	input  logic [exe_pkg::REG_ADDR_W-1:0] rd_addr_i,
	input  logic                           out_ready_i,
	output logic                           out_valid_o,
	output logic [exe_pkg::XLEN-1:0]       result_o,
	output logic [exe_pkg::REG_ADDR_W-1:0] rd_addr_o,
	output logic                           rd_we_o,
	output logic [exe_pkg::XLEN-1:0]       next_pc_o,
	output logic                           branch_taken_o
);
	import exe_pkg::*;

	logic [XLEN-1:0]       link;        // pc + 4
	logic [XLEN-1:0]       alu_sh1;
	logic [XLEN-1:0]       result_d;
	logic [XLEN-1:0]       next_pc_d;
	logic [REG_ADDR_W-1:0] pend_rd_q;   // Fields of a running long shift
	logic [XLEN-1:0]       pend_pc_q;
	logic                  from_shift;

	assign link       = pc_i + XLEN'(PC_STEP);
	assign next_pc_d  = (pc_sel_i && taken_i) ? target_i : link;
	assign from_shift = (wb_sel_i == WB_SHIFTER);

	always_comb begin
		case (shift_mode_i)
			SHIFT_LEFT:   alu_sh1 = {alu_result_i[XLEN-2:0], 1'b0};
			SHIFT_RIGHT:  alu_sh1 = {1'b0, alu_result_i[XLEN-1:1]};
			SHIFT_ARIGHT: alu_sh1 = {alu_result_i[XLEN-1], alu_result_i[XLEN-1:1]};
			default:      alu_sh1 = alu_result_i;
		endcase
	end

	always_comb begin
		case (wb_sel_i)
			WB_ALU_SH1: result_d = alu_sh1;
			WB_SHIFTER: result_d = shift.result;
			WB_SLT:     result_d = {{(XLEN-1){1'b0}}, stat_i.negative};
			WB_SLTU:    result_d = {{(XLEN-1){1'b0}}, stat_i.carry};
			WB_PC_IMM:  result_d = pc_i + imm_i;
			WB_LINK:    result_d = link;
			WB_IMM:     result_d = imm_i;
			default:    result_d = alu_result_i;
		endcase
	end

	// Inputs move on after a long shift is accepted
	always_ff @(posedge clk_i) begin
		if (shift.start) begin
			pend_rd_q <= rd_addr_i;
			pend_pc_q <= link;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rstn_i)
			out_valid_o <= 1'b0;
		else if (load_i)
			out_valid_o <= 1'b1;
		else if (out_ready_i)
			out_valid_o <= 1'b0;  // Consumed, nothing new
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			result_o       <= result_d;
			rd_addr_o      <= from_shift ? pend_rd_q : rd_addr_i;
			rd_we_o        <= rd_we_i;
			next_pc_o      <= from_shift ? pend_pc_q : next_pc_d;
			branch_taken_o <= pc_sel_i && taken_i;
		end
	end

	a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(result_o) &&
		$stable(rd_addr_o) && $stable(rd_we_o) && $stable(next_pc_o) &&
		$stable(branch_taken_o)));

endmodule

//--- exe_stage.f
+incdir+verification
design/exe_pkg.sv
design/exe_shift_if.sv
design/exe_alu.sv
design/exe_shifter.sv
design/exe_branch_unit.sv
design/exe_control.sv
design/exe_writeback.sv
design/exe_stage.sv
verification/tb_exe_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exe_stage.f --top-module tb_exe_stage

output=$(./obj_dir/Vtb_exe_stage)
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
	exit 0
fi
exit 1

//--- verification/exe_ref_model.svh
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

// Expected output fields of one instruction
typedef struct packed {
	logic [31:0] result;
	logic [4:0]  rd_addr;
	logic        rd_we;
	logic [31:0] next_pc;
	logic        taken;
} exp_rec_t;

// Branch conditions straight from the ISA definitions
function automatic logic cond_taken(input exe_op_t op, input logic [31:0] a,
		input logic [31:0] b);
	case (op)
		OP_BEQ:  return a == b;
		OP_BNE:  return a != b;
		OP_BLT:  return $signed(a) < $signed(b);
		OP_BGE:  return $signed(a) >= $signed(b);
		OP_BLTU: return a < b;
		OP_BGEU: return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic exp_rec_t model_execute(input exe_op_t op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] imm, input logic [31:0] pc,
		input logic [4:0] rd);
	exp_rec_t   r;
	logic [4:0] sh;
	logic [31:0] seq;
	sh = b[4:0];          // Only the low five bits count
	seq = pc + 32'd4;     // Fall-through address
	r.result = '0;
	r.rd_addr = rd;
	r.rd_we = 1'b1;
	r.next_pc = seq;
	r.taken = 1'b0;
	case (op)
		OP_ADD:   r.result = a + b;
		OP_SUB:   r.result = a - b;
		OP_AND:   r.result = a & b;
		OP_OR:    r.result = a | b;
		OP_XOR:   r.result = a ^ b;
		OP_SLT:   r.result = {31'b0, $signed(a) < $signed(b)};
		OP_SLTU:  r.result = {31'b0, a < b};
		OP_SLL:   r.result = a << sh;
		OP_SRL:   r.result = a >> sh;
		OP_SRA:   r.result = $signed(a) >>> sh;
		OP_LUI:   r.result = imm;       // Immediate arrives pre-shifted
		OP_AUIPC: r.result = pc + imm;
		OP_JAL, OP_JALR: begin
			r.result = seq;             // Link address
			r.taken = 1'b1;
			r.next_pc = (op == OP_JALR) ? ((a + imm) & ~32'd1) : (pc + imm);
		end
		default: begin
			r.rd_we = 1'b0;             // Branches leave the register file alone
			r.taken = cond_taken(op, a, b);
			if (r.taken)
				r.next_pc = pc + imm;
		end
	endcase
	return r;
endfunction

`endif

//--- verification/tb_exe_stage.sv
`timescale 1ns/1ns

module tb_exe_stage;
	import exe_pkg::*;
	`include "exe_ref_model.svh"

	localparam int          PERIOD_NS    = 4;
	localparam int          RESET_CYCLES = 4;
	localparam logic [31:0] SEED         = 32'h5cbf7c0b;
	localparam int          N_ALU        = 140;
	localparam int          N_SHIFT      = 90;
	localparam int          N_UJ         = 60;
	localparam int          N_BR         = 120;
	localparam int          N_MIX        = 200;
	localparam int          N_TOTAL      = N_ALU + N_SHIFT + N_UJ + N_BR + N_MIX;
	localparam int          MAX_STALL    = 4;   // Longest run of idle or stalled cycles
	localparam int          WATCHDOG_NS  = N_TOTAL * (31 + MAX_STALL + 2) * PERIOD_NS
	                                       + (RESET_CYCLES + 10) * PERIOD_NS;

	logic                  clk_i;
	logic                  rstn_i;
	logic                  in_valid_i;
	logic                  in_ready_o;
	exe_op_t               op_i;
	logic [XLEN-1:0]       operand_a_i;
	logic [XLEN-1:0]       operand_b_i;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       pc_i;
	logic [REG_ADDR_W-1:0] rd_addr_i;
	logic                  out_valid_o;
	logic                  out_ready_i;
	logic [XLEN-1:0]       result_o;
	logic [REG_ADDR_W-1:0] rd_addr_o;
	logic                  rd_we_o;
	logic [XLEN-1:0]       next_pc_o;
	logic                  branch_taken_o;

	logic [31:0] rng_state = SEED;
	exp_rec_t    exp_q[$];          // Scoreboard, oldest first
	exp_rec_t    held;              // Outputs seen at the last sample
	string       test_name = "reset_state";
	int          errors = 0;
	int          err_start = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          stall_run = 0;
	logic        bp_enable = 1'b0;  // Random out_ready when set
	logic        stall_prev = 1'b0;
	logic        long_pending = 1'b0;

	exe_stage exe_stage_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD_NS / 2) clk_i = ~clk_i;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Leans toward the signed and unsigned boundaries
	function automatic logic [31:0] biased_operand();
		logic [31:0] r;
		r = next_rand();
		case (r[2:0])
			3'd0:    return 32'h8000_0000;
			3'd1:    return 32'h7fff_ffff;
			3'd2:    return 32'hffff_ffff;
			3'd3:    return {31'b0, r[31]};
			default: return next_rand();
		endcase
	endfunction

	function automatic logic is_long_shift(input exe_op_t op, input logic [31:0] b);
		return (op == OP_SLL || op == OP_SRL || op == OP_SRA) && (b[4:0] >= 5'd2);
	endfunction

	function automatic exp_rec_t current_outputs();
		exp_rec_t c;
		c.result = result_o;
		c.rd_addr = rd_addr_o;
		c.rd_we = rd_we_o;
		c.next_pc = next_pc_o;
		c.taken = branch_taken_o;
		return c;
	endfunction

	task automatic check_value(input string field, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch: test %s, %s expected %h actual %h", test_name, field, exp, act);
			errors++;
		end
	endtask

	task automatic compare_record(input string what, input exp_rec_t e, input logic with_result);
		exp_rec_t c;
		c = current_outputs();
		if (with_result)
			check_value({what, " result"}, e.result, c.result);
		check_value({what, " rd_addr"}, 32'(e.rd_addr), 32'(c.rd_addr));
		check_value({what, " rd_we"}, 32'(e.rd_we), 32'(c.rd_we));
		check_value({what, " next_pc"}, e.next_pc, c.next_pc);
		check_value({what, " branch_taken"}, 32'(e.taken), 32'(c.taken));
	endtask

	// All stimulus changes on the falling edge
	task automatic next_cycle();
		logic [31:0] r;
		@(negedge clk_i);
		r = next_rand();
		if (bp_enable && !r[0] && stall_run < MAX_STALL) begin
			out_ready_i = 1'b0;
			stall_run++;
		end else begin
			out_ready_i = 1'b1;
			stall_run = 0;
		end
	endtask

	// Holds the instruction until the DUT takes it
	task automatic issue(input exe_op_t op, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] imm, input logic [31:0] pc, input logic [4:0] rd);
		logic accepted;
		in_valid_i = 1'b1;
		op_i = op;
		operand_a_i = a;
		operand_b_i = b;
		imm_i = imm;
		pc_i = pc;
		rd_addr_i = rd;
		accepted = 1'b0;
		while (!accepted) begin
			#1;
			accepted = in_ready_o;
			next_cycle();
		end
		in_valid_i = 1'b0;
	endtask

	task automatic random_fields(input exe_op_t op, output logic [31:0] a,
			output logic [31:0] b, output logic [31:0] imm, output logic [31:0] pc,
			output logic [4:0] rd);
		logic [31:0] r;
		a = biased_operand();
		b = biased_operand();
		r = next_rand();
		pc = {r[31:2], 2'b00};
		r = next_rand();
		imm = {{19{r[12]}}, r[12:0]};              // Branch-sized offset
		if (op == OP_LUI)
			imm = {r[31:12], 12'b0};
		if (op == OP_JAL)
			imm = {{11{r[20]}}, r[20:1], 1'b0};
		r = next_rand();
		rd = r[4:0];
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_start = errors;
	endtask

	task automatic end_test();
		bp_enable = 1'b0;
		while (exp_q.size() != 0)
			next_cycle();
		if (errors == err_start) begin
			tests_passed++;
			$display("Test %s finished: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s finished: %0d errors", test_name, errors - err_start);
		end
	endtask

	// Samples just after the falling edge, ahead of the next rising edge
	initial begin : monitor
		exp_rec_t e;
		forever begin
			@(negedge clk_i);
			#1;
			if (rstn_i) begin
				if (stall_prev) begin
					check_value("stalled out_valid", 32'd1, 32'(out_valid_o));
					compare_record("stalled", held, 1'b1);
				end
				if (long_pending) begin
					if (out_valid_o)
						long_pending = 1'b0;
					else
						check_value("in_ready during shift", 32'd0, 32'(in_ready_o));
				end
				if (in_valid_i && in_ready_o) begin
					exp_q.push_back(model_execute(op_i, operand_a_i, operand_b_i, imm_i,
						pc_i, rd_addr_i));
					if (is_long_shift(op_i, operand_b_i))
						long_pending = 1'b1;
				end
				if (out_valid_o && out_ready_i) begin
					if (exp_q.size() == 0) begin
						$display("Test %s: an output appeared with no instruction outstanding",
							test_name);
						errors++;
					end else begin
						e = exp_q.pop_front();
						compare_record("output", e, e.rd_we);   // Branch result is don't-care
					end
				end
				stall_prev = out_valid_o && !out_ready_i;
				held = current_outputs();
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	initial begin : stimulus
		int          i;
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [4:0]  rd;
		exe_op_t     op;
		rstn_i = 1'b0;
		in_valid_i = 1'b0;
		op_i = OP_ADD;
		operand_a_i = '0;
		operand_b_i = '0;
		imm_i = '0;
		pc_i = '0;
		rd_addr_i = '0;
		out_ready_i = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_i);
		rstn_i = 1'b1;

		begin_test("reset_state");
		#1;
		check_value("out_valid after reset", 32'd0, 32'(out_valid_o));
		check_value("in_ready after reset", 32'd1, 32'(in_ready_o));
		next_cycle();
		end_test();

		begin_test("alu_slt");
		for (i = 0; i < N_ALU; i++) begin
			r = next_rand();
			op = exe_op_t'(5'(int'(OP_ADD) + r % 7));
			random_fields(op, a, b, imm, pc, rd);
			issue(op, a, b, imm, pc, rd);
		end
		end_test();

		begin_test("shifts");
		for (i = 0; i < N_SHIFT; i++) begin
			r = next_rand();
			op = (r[1:0] == 2'd0) ? OP_SLL : ((r[1:0] == 2'd1) ? OP_SRL : OP_SRA);
			random_fields(op, a, b, imm, pc, rd);
			a = next_rand();
			case (i % 3)
				0:       b = {b[31:5], 5'd0};
				1:       b = {b[31:5], 5'd1};
				default: b = {b[31:5], 5'(2 + next_rand() % 30)};  // Sequential path
			endcase
			issue(op, a, b, imm, pc, rd);
		end
		end_test();

		begin_test("upper_jump");
		for (i = 0; i < N_UJ; i++) begin
			r = next_rand();
			op = exe_op_t'(5'(int'(OP_LUI) + r % 4));
			random_fields(op, a, b, imm, pc, rd);
			issue(op, a, b, imm, pc, rd);
		end
		end_test();

		begin_test("branches");
		for (i = 0; i < N_BR; i++) begin
			r = next_rand();
			op = exe_op_t'(5'(int'(OP_BEQ) + r % 6));
			random_fields(op, a, b, imm, pc, rd);
			if (i % 2 == 1)
				b = a;                             // Equal pair
			issue(op, a, b, imm, pc, rd);
		end
		end_test();

		begin_test("backpressure_order");
		bp_enable = 1'b1;
		for (i = 0; i < N_MIX; i++) begin
			r = next_rand();
			op = exe_op_t'(5'(r % 20));
			random_fields(op, a, b, imm, pc, rd);
			r = next_rand();
			if (r[1:0] == 2'd0)
				repeat (1 + r[3:2]) next_cycle();   // Idle gap on the input
			issue(op, a, b, imm, pc, rd);
		end
		end_test();

		$display("Tests run: %0d, passed: %0d, failed: %0d", tests_passed + tests_failed,
			tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
